//--- hdl/ti_map_pkg.sv
`default_nettype none
//----------------------------------------
// Shared widths, region codes and base
// addresses of the memory-mapping core,
// plus the two-view CPU address word
//----------------------------------------
package ti_map_pkg;

  // Bus widths
  localparam int unsigned ADDR_W  = 16;  // CPU byte address
  localparam int unsigned DATA_W  = 16;  // CPU data word
  localparam int unsigned XADDR_W = 23;  // External word address

  //----------------------------------------
  // Region codes from stage 1
  //----------------------------------------
  localparam int unsigned REGION_W = 4;
  localparam logic [REGION_W-1:0] REG_ROM       = 4'd0;  // 0000..1FFF boot ROM
  localparam logic [REGION_W-1:0] REG_EXP       = 4'd1;  // 32K expansion RAM
  localparam logic [REGION_W-1:0] REG_SAMS_REGS = 4'd2;  // Page registers at 4000
  localparam logic [REGION_W-1:0] REG_CART      = 4'd3;  // 6000..7FFF cartridge
  localparam logic [REGION_W-1:0] REG_SCRATCH   = 4'd4;  // 8000..83FF scratchpad
  localparam logic [REGION_W-1:0] REG_WINDOW    = 4'd5;  // 8500..85FF window
  localparam logic [REGION_W-1:0] REG_WINREG    = 4'd6;  // 8600 window register
  localparam logic [REGION_W-1:0] REG_NONE      = 4'd7;  // Nothing mapped

  // Kind of access handed to stage 3
  localparam int unsigned KIND_W = 2;
  localparam logic [KIND_W-1:0] KIND_RD  = 2'd0;  // External memory read
  localparam logic [KIND_W-1:0] KIND_WR  = 2'd1;  // External memory write
  localparam logic [KIND_W-1:0] KIND_INT = 2'd2;  // Completed inside the core

  // Placement in external memory, word addresses
  localparam logic [XADDR_W-1:0] CART_BASE = 23'h100000;  // 256 cart pages of 8K bytes
  localparam logic [XADDR_W-1:0] SAMS_BASE = 23'h040000;  // 256 mapper pages of 4K bytes
  localparam logic [7:0]         CRU_SAMS_BASE = 8'h1E;   // CRU bits at 1E00

  // Mapper
  localparam int unsigned PAGE_W        = 8;
  localparam int unsigned NUM_PAGE_REGS = 16;

  //----------------------------------------
  // One CPU address word, two decodings
  //----------------------------------------
  typedef union packed {
    struct packed {
      logic [3:0]  nibble;   // 4K region, also the mapper lookup index
      logic [11:0] offset;
    } mem;
    struct packed {
      logic [7:0] base;      // CRU device select
      logic [6:0] bit_idx;   // CRU bit number
      logic       spare;     // Byte lane, ignored by CRU
    } cru;
  } cpu_addr_u;

endpackage
`default_nettype wire

//--- hdl/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------------------
// Stage 1: catches the start of each CPU
// cycle, classifies the address into a
// region and owns the SAMS CRU bits
//----------------------------------------
module bus_decode (
  input  logic                              clk,
  input  logic                              cpu_reset,
  input  logic [ti_map_pkg::ADDR_W-1:0]     cpu_addr_i,
  input  logic [ti_map_pkg::DATA_W-1:0]     cpu_data_i,
  input  logic                              cpu_rd_i,
  input  logic                              cpu_wr_i,
  input  logic                              cru_clk_i,
  input  logic                              cru_bit_i,
  output logic                              dec_valid_o,   // One pulse per CPU cycle
  output logic [ti_map_pkg::REGION_W-1:0]   dec_region_o,
  output logic [ti_map_pkg::ADDR_W-1:0]     dec_addr_o,
  output logic                              dec_wr_o,
  output logic [ti_map_pkg::DATA_W-1:0]     dec_data_o,
  output logic                              sams_mapen_o   // CRU 1E02, mapping on
);

  ti_map_pkg::cpu_addr_u cpu_a;           // Address seen as memory or CRU
  logic                  rd_q, wr_q;      // Strobes one cycle back
  logic                  cru_clk_q;
  logic                  sams_en;         // CRU 1E00, registers visible at 4000
  logic                  new_cycle;
  logic [ti_map_pkg::REGION_W-1:0] region;

  assign cpu_a     = cpu_addr_i;
  assign new_cycle = (cpu_rd_i && !rd_q) || (cpu_wr_i && !wr_q);  // Rising strobe

  //----------------------------------------
  // Region decode
  //----------------------------------------
  always_comb begin
    case (cpu_a.mem.nibble)
      4'h0, 4'h1: region = ti_map_pkg::REG_ROM;
      4'h2, 4'h3: region = ti_map_pkg::REG_EXP;        // Low 8K of expansion
      4'h4, 4'h5: begin
        // Page registers only while enabled over CRU
        region = sams_en ? ti_map_pkg::REG_SAMS_REGS : ti_map_pkg::REG_NONE;
      end
      4'h6, 4'h7: region = ti_map_pkg::REG_CART;
      4'h8: begin
        if (cpu_a.mem.offset[11:10] == 2'b00)
          region = ti_map_pkg::REG_SCRATCH;            // 8000..83FF
        else if (cpu_a.mem.offset[11:8] == 4'h5)
          region = ti_map_pkg::REG_WINDOW;             // 8500..85FF
        else if (cpu_a.mem.offset[11:8] == 4'h6)
          region = ti_map_pkg::REG_WINREG;             // 8600..86FF
        else
          region = ti_map_pkg::REG_NONE;               // Video, sound and such
      end
      4'h9:    region = ti_map_pkg::REG_NONE;          // GROM and speech ports
      default: region = ti_map_pkg::REG_EXP;           // A000..FFFF
    endcase
  end

  // Control state
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      rd_q         <= 1'b0;
      wr_q         <= 1'b0;
      dec_valid_o  <= 1'b0;
      cru_clk_q    <= 1'b0;
      sams_en      <= 1'b0;
      sams_mapen_o <= 1'b0;
    end else begin
      rd_q        <= cpu_rd_i;
      wr_q        <= cpu_wr_i;
      dec_valid_o <= new_cycle;
      cru_clk_q   <= cru_clk_i;
      // CRU bit write on rising cru_clk at base 1E
      if (cru_clk_i && !cru_clk_q && cpu_a.cru.base == ti_map_pkg::CRU_SAMS_BASE) begin
        if (cpu_a.cru.bit_idx == 7'd0)
          sams_en <= cru_bit_i;
        else if (cpu_a.cru.bit_idx == 7'd1)
          sams_mapen_o <= cru_bit_i;
      end
    end
  end

  // Cycle payload, captured with the valid pulse
  always_ff @(posedge clk) begin
    if (new_cycle) begin
      dec_region_o <= region;
      dec_addr_o   <= cpu_addr_i;
      dec_wr_o     <= cpu_wr_i;
      dec_data_o   <= cpu_data_i;
    end
  end

  // CPU never reads and writes in one cycle
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (cpu_reset)
    !(cpu_rd_i && cpu_wr_i))
    else $error("bus_decode: rd and wr high together");

endmodule
`default_nettype wire

//--- hdl/sams_mapper.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------------------
// SAMS page register file. Translates a
// 4K region nibble into a page number
//----------------------------------------
module sams_mapper (
  input  logic                            clk,
  input  logic                            wr_i,      // Register write strobe
  input  logic [3:0]                      idx_i,     // Register picked by the CPU
  input  logic [ti_map_pkg::PAGE_W-1:0]   wdata_i,
  input  logic [3:0]                      lookup_i,  // Region nibble to translate
  input  logic                            mapen_i,
  output logic [ti_map_pkg::PAGE_W-1:0]   page_o,
  output logic [ti_map_pkg::PAGE_W-1:0]   rdata_o
);

  // One page per 4K region of the CPU space
  logic [ti_map_pkg::PAGE_W-1:0] page_regs [ti_map_pkg::NUM_PAGE_REGS];

  always_ff @(posedge clk) begin
    if (wr_i)
      page_regs[idx_i] <= wdata_i;
  end

  // Pass-through mode maps each region onto its own page
  assign page_o  = mapen_i ? page_regs[lookup_i] : {4'h0, lookup_i};
  assign rdata_o = page_regs[idx_i];       // Register readback

endmodule
`default_nettype wire

//--- hdl/addr_translate.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------------------
// Stage 2: holds cartridge bank and window
// registers, looks up SAMS pages and forms
// the external word address
//----------------------------------------
module addr_translate (
  input  logic                              clk,
  input  logic                              cpu_reset,
  input  logic                              dec_valid_i,
  input  logic [ti_map_pkg::REGION_W-1:0]   dec_region_i,
  input  logic [ti_map_pkg::ADDR_W-1:0]     dec_addr_i,
  input  logic                              dec_wr_i,
  input  logic [ti_map_pkg::DATA_W-1:0]     dec_data_i,
  input  logic                              sams_mapen_i,
  output logic                              xl_valid_o,
  output logic [ti_map_pkg::KIND_W-1:0]     xl_kind_o,
  output logic [ti_map_pkg::XADDR_W-1:0]    xl_addr_o,
  output logic [ti_map_pkg::DATA_W-1:0]     xl_wdata_o,
  output logic [ti_map_pkg::DATA_W-1:0]     xl_rdata_o   // Read data of internal kinds
);

  ti_map_pkg::cpu_addr_u dec_a;
  logic [ti_map_pkg::PAGE_W-1:0]  cart_page;   // Bank latched from a cart write
  logic [ti_map_pkg::PAGE_W-1:0]  map_page;
  logic [ti_map_pkg::PAGE_W-1:0]  map_rdata;
  logic [ti_map_pkg::DATA_W-1:0]  win_reg;     // Window base, 256 byte units
  logic                           map_wr, cart_wr, win_wr;
  logic [ti_map_pkg::KIND_W-1:0]  kind;
  logic [ti_map_pkg::XADDR_W-1:0] xaddr;
  logic [ti_map_pkg::DATA_W-1:0]  rdata;

  assign dec_a   = dec_addr_i;
  assign map_wr  = dec_valid_i && dec_wr_i && dec_region_i == ti_map_pkg::REG_SAMS_REGS;
  assign cart_wr = dec_valid_i && dec_wr_i && dec_region_i == ti_map_pkg::REG_CART;
  assign win_wr  = dec_valid_i && dec_wr_i && dec_region_i == ti_map_pkg::REG_WINREG;

  // Register index from address bits 4..1, data in the high byte
  sams_mapper sams_mapper_inst (
    .clk      (clk),
    .wr_i     (map_wr),
    .idx_i    (dec_addr_i[4:1]),
    .wdata_i  (dec_data_i[15:8]),
    .lookup_i (dec_a.mem.nibble),
    .mapen_i  (sams_mapen_i),
    .page_o   (map_page),
    .rdata_o  (map_rdata)
  );

  //----------------------------------------
  // Address and kind per region
  //----------------------------------------
  always_comb begin
    kind  = dec_wr_i ? ti_map_pkg::KIND_WR : ti_map_pkg::KIND_RD;
    xaddr = '0;
    rdata = '0;
    case (dec_region_i)
      ti_map_pkg::REG_ROM, ti_map_pkg::REG_SCRATCH: begin
        xaddr = {8'h00, dec_addr_i[15:1]};              // Direct word address
        if (dec_region_i == ti_map_pkg::REG_ROM && dec_wr_i)
          kind = ti_map_pkg::KIND_INT;                  // ROM is write protected
      end
      ti_map_pkg::REG_EXP:
        xaddr = ti_map_pkg::SAMS_BASE + {4'h0, map_page, dec_a.mem.offset[11:1]};
      ti_map_pkg::REG_CART: begin
        xaddr = ti_map_pkg::CART_BASE + {3'b000, cart_page, dec_addr_i[12:1]};
        if (dec_wr_i)
          kind = ti_map_pkg::KIND_INT;                  // Bank switch only
      end
      ti_map_pkg::REG_WINDOW:
        xaddr = {win_reg, dec_addr_i[7:1]};
      ti_map_pkg::REG_SAMS_REGS: begin
        kind  = ti_map_pkg::KIND_INT;
        rdata = {map_rdata, map_rdata};                 // Byte in both halves
      end
      ti_map_pkg::REG_WINREG: begin
        kind  = ti_map_pkg::KIND_INT;
        rdata = win_reg;
      end
      default: kind = ti_map_pkg::KIND_INT;             // Unmapped, reads zero
    endcase
  end

  // Control state and mapping registers
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      xl_valid_o <= 1'b0;
      cart_page  <= '0;
      win_reg    <= '0;
    end else begin
      xl_valid_o <= dec_valid_i;
      if (cart_wr)
        cart_page <= dec_addr_i[8:1];                   // Page from the address bus
      if (win_wr)
        win_reg <= dec_data_i;
    end
  end

  // Payload towards stage 3
  always_ff @(posedge clk) begin
    if (dec_valid_i) begin
      xl_kind_o  <= kind;
      xl_addr_o  <= xaddr;
      xl_wdata_o <= dec_data_i;
      xl_rdata_o <= rdata;
    end
  end

endmodule
`default_nettype wire

//--- hdl/mem_request.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------------------
// Stage 3 drives the request/ack handshake
// to the external memory and the held
// ready to the CPU
//----------------------------------------
module mem_request (
  input  logic                             clk,
  input  logic                             cpu_reset,
  input  logic                             cpu_rd_i,
  input  logic                             cpu_wr_i,
  input  logic                             xl_valid_i,
  input  logic [ti_map_pkg::KIND_W-1:0]    xl_kind_i,
  input  logic [ti_map_pkg::XADDR_W-1:0]   xl_addr_i,
  input  logic [ti_map_pkg::DATA_W-1:0]    xl_wdata_i,
  input  logic [ti_map_pkg::DATA_W-1:0]    xl_rdata_i,
  input  logic                             mem_ack_i,
  input  logic [ti_map_pkg::DATA_W-1:0]    mem_rdata_i,   // Valid with the ack
  output logic [ti_map_pkg::XADDR_W-1:0]   mem_addr_o,
  output logic [ti_map_pkg::DATA_W-1:0]    mem_wdata_o,
  output logic                             mem_rd_rq_o,
  output logic                             mem_wr_rq_o,
  output logic [ti_map_pkg::DATA_W-1:0]    cpu_rdata_o,
  output logic                             cpu_ready_o
);

  logic req_busy;     // A request is out
  logic mem_done;     // Memory accepted it this cycle
  logic int_done;     // Access served inside the core

  assign req_busy = mem_rd_rq_o || mem_wr_rq_o;
  assign mem_done = req_busy && mem_ack_i;
  assign int_done = xl_valid_i && xl_kind_i == ti_map_pkg::KIND_INT;

  // Requests and held ready
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      mem_rd_rq_o <= 1'b0;
      mem_wr_rq_o <= 1'b0;
      cpu_ready_o <= 1'b0;
    end else begin
      if (xl_valid_i) begin
        mem_rd_rq_o <= xl_kind_i == ti_map_pkg::KIND_RD;
        mem_wr_rq_o <= xl_kind_i == ti_map_pkg::KIND_WR;
      end else if (mem_done) begin
        mem_rd_rq_o <= 1'b0;                   // Drop the cycle after the ack
        mem_wr_rq_o <= 1'b0;
      end
      if (!cpu_rd_i && !cpu_wr_i)
        cpu_ready_o <= 1'b0;                   // CPU has ended its cycle
      else if (mem_done || int_done)
        cpu_ready_o <= 1'b1;
    end
  end

  // Address, write data and read word
  always_ff @(posedge clk) begin
    if (xl_valid_i) begin
      mem_addr_o  <= xl_addr_i;
      mem_wdata_o <= xl_wdata_i;
    end
    if (int_done)
      cpu_rdata_o <= xl_rdata_i;
    else if (mem_done && mem_rd_rq_o)
      cpu_rdata_o <= mem_rdata_i;
  end

  //----------------------------------------
  // Handshake rules
  //----------------------------------------
  // One access at a time towards memory
  a_one_request: assert property (@(posedge clk) disable iff (cpu_reset)
    !(xl_valid_i && req_busy))
    else $error("mem_request: new access arrived while a request is out");

  a_req_held: assert property (@(posedge clk) disable iff (cpu_reset)
    (req_busy && !mem_ack_i) |=> (req_busy && $stable(mem_addr_o)))
    else $error("mem_request: request dropped or address moved before ack");

endmodule
`default_nettype wire

//--- hdl/ti_mem_map.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------------------
// Memory-mapping core top level. CPU bus
// in, external word-addressed memory out,
// three pipeline stages in between
//----------------------------------------
module ti_mem_map (
  input  logic                             clk,
  input  logic                             cpu_reset,
  // CPU side
  input  logic [ti_map_pkg::ADDR_W-1:0]    cpu_addr_i,
  input  logic [ti_map_pkg::DATA_W-1:0]    cpu_data_i,
  input  logic                             cpu_rd_i,
  input  logic                             cpu_wr_i,
  input  logic                             cru_clk_i,
  input  logic                             cru_bit_i,
  output logic [ti_map_pkg::DATA_W-1:0]    cpu_rdata_o,
  output logic                             cpu_ready_o,
  // Memory side
  output logic [ti_map_pkg::XADDR_W-1:0]   mem_addr_o,
  output logic [ti_map_pkg::DATA_W-1:0]    mem_wdata_o,
  output logic                             mem_rd_rq_o,
  output logic                             mem_wr_rq_o,
  input  logic                             mem_ack_i,
  input  logic [ti_map_pkg::DATA_W-1:0]    mem_rdata_i
);

  // Stage 1 to stage 2
  logic                             dec_valid;
  logic [ti_map_pkg::REGION_W-1:0]  dec_region;
  logic [ti_map_pkg::ADDR_W-1:0]    dec_addr;
  logic                             dec_wr;
  logic [ti_map_pkg::DATA_W-1:0]    dec_data;
  logic                             sams_mapen;
  // Stage 2 to stage 3
  logic                             xl_valid;
  logic [ti_map_pkg::KIND_W-1:0]    xl_kind;
  logic [ti_map_pkg::XADDR_W-1:0]   xl_addr;
  logic [ti_map_pkg::DATA_W-1:0]    xl_wdata;
  logic [ti_map_pkg::DATA_W-1:0]    xl_rdata;

  bus_decode bus_decode_inst (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_data_i   (cpu_data_i),
    .cpu_rd_i     (cpu_rd_i),
    .cpu_wr_i     (cpu_wr_i),
    .cru_clk_i    (cru_clk_i),
    .cru_bit_i    (cru_bit_i),
    .dec_valid_o  (dec_valid),
    .dec_region_o (dec_region),
    .dec_addr_o   (dec_addr),
    .dec_wr_o     (dec_wr),
    .dec_data_o   (dec_data),
    .sams_mapen_o (sams_mapen)
  );

  addr_translate addr_translate_inst (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .dec_valid_i  (dec_valid),
    .dec_region_i (dec_region),
    .dec_addr_i   (dec_addr),
    .dec_wr_i     (dec_wr),
    .dec_data_i   (dec_data),
    .sams_mapen_i (sams_mapen),
    .xl_valid_o   (xl_valid),
    .xl_kind_o    (xl_kind),
    .xl_addr_o    (xl_addr),
    .xl_wdata_o   (xl_wdata),
    .xl_rdata_o   (xl_rdata)
  );

  mem_request mem_request_inst (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .cpu_rd_i     (cpu_rd_i),
    .cpu_wr_i     (cpu_wr_i),
    .xl_valid_i   (xl_valid),
    .xl_kind_i    (xl_kind),
    .xl_addr_i    (xl_addr),
    .xl_wdata_i   (xl_wdata),
    .xl_rdata_i   (xl_rdata),
    .mem_ack_i    (mem_ack_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rd_rq_o  (mem_rd_rq_o),
    .mem_wr_rq_o  (mem_wr_rq_o),
    .cpu_rdata_o  (cpu_rdata_o),
    .cpu_ready_o  (cpu_ready_o)
  );

endmodule
`default_nettype wire

//--- dv/tb_ti_mem_map.sv
`timescale 1ns/1ps
`default_nettype none
//----------------------------------------
// Testbench for the memory-mapping core.
// Plays the CPU and the external memory
// and checks the responses with
// concurrent assertions
//----------------------------------------
module tb_ti_mem_map;

  localparam int unsigned READY_TIMEOUT = 40;  // Cycles allowed per access
  localparam bit RD  = 1'b0;
  localparam bit WR  = 1'b1;
  localparam bit MEM = 1'b1;                   // Goes out to memory
  localparam bit INT = 1'b0;                   // Served inside the core

  logic        clk         = 1'b0;
  logic        cpu_reset   = 1'b1;
  logic [15:0] cpu_addr_i  = '0;
  logic [15:0] cpu_data_i  = '0;
  logic        cpu_rd_i    = 1'b0;
  logic        cpu_wr_i    = 1'b0;
  logic        cru_clk_i   = 1'b0;
  logic        cru_bit_i   = 1'b0;
  logic        mem_ack_i   = 1'b0;
  logic [15:0] mem_rdata_i = '0;
  logic [15:0] cpu_rdata_o;
  logic        cpu_ready_o;
  logic [22:0] mem_addr_o;
  logic [15:0] mem_wdata_o;
  logic        mem_rd_rq_o;
  logic        mem_wr_rq_o;

  // Expectations for the access in flight
  logic        seen_strobe = 1'b0;
  logic        exp_mem     = 1'b0;
  logic [22:0] exp_addr    = '0;
  logic [15:0] exp_rdata   = '0;
  // Memory model state
  int unsigned ack_wait     = 0;
  logic        armed        = 1'b0;
  logic [22:0] last_wr_addr = '0;
  logic [15:0] last_wr_data = '0;
  int          errors       = 0;

  always #20 clk = ~clk;                       // 40 ns period

  ti_mem_map ti_mem_map_inst (.*);             // Port names match one to one

  //----------------------------------------
  // Memory responder
  //----------------------------------------
  always @(posedge clk) begin
    if (cpu_reset) begin
      mem_ack_i <= 1'b0;
      armed     <= 1'b0;
    end else if (mem_ack_i) begin
      mem_ack_i <= 1'b0;                           // One-cycle ack
    end else if (mem_rd_rq_o || mem_wr_rq_o) begin
      if (!armed) begin
        ack_wait <= $urandom_range(5, 0);          // Random back-pressure
        armed    <= 1'b1;
      end else if (ack_wait == 0) begin
        mem_ack_i   <= 1'b1;
        mem_rdata_i <= mem_addr_o[15:0] ^ 16'h5A5A;  // Data tied to address
        armed       <= 1'b0;
        if (mem_wr_rq_o) begin
          last_wr_addr <= mem_addr_o;
          last_wr_data <= mem_wdata_o;
        end
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  function automatic void report_mismatch(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endfunction

  //----------------------------------------
  // Checks
  //----------------------------------------
  a_idle: assert property (@(posedge clk) disable iff (cpu_reset)
    !seen_strobe |-> !(mem_rd_rq_o || mem_wr_rq_o || cpu_ready_o))
    else report_mismatch("bus active before the first CPU strobe");

  a_rd_req: assert property (@(posedge clk) disable iff (cpu_reset)
    $rose(cpu_rd_i) && exp_mem |-> ##2 !mem_rd_rq_o ##1 (mem_rd_rq_o && mem_addr_o == exp_addr))
    else report_mismatch("read request late, early or at the wrong address");

  a_wr_req: assert property (@(posedge clk) disable iff (cpu_reset)
    $rose(cpu_wr_i) && exp_mem |-> ##2 !mem_wr_rq_o
      ##1 (mem_wr_rq_o && mem_addr_o == exp_addr && mem_wdata_o == cpu_data_i))
    else report_mismatch("write request late, early or with wrong address or data");

  a_internal: assert property (@(posedge clk) disable iff (cpu_reset)
    $rose(cpu_rd_i || cpu_wr_i) && !exp_mem |-> ##3 (cpu_ready_o && !mem_rd_rq_o && !mem_wr_rq_o))
    else report_mismatch("internal access without ready or with a memory request");

  a_rdata: assert property (@(posedge clk) disable iff (cpu_reset)
    $rose(cpu_ready_o) && cpu_rd_i |-> cpu_rdata_o == exp_rdata)
    else report_mismatch("wrong read data with ready");

  a_ready_after_ack: assert property (@(posedge clk) disable iff (cpu_reset)
    $rose(cpu_ready_o) && exp_mem |-> $past(mem_ack_i))
    else report_mismatch("ready rose before the memory ack");

  a_req_until_ack: assert property (@(posedge clk) disable iff (cpu_reset)
    $fell(mem_rd_rq_o || mem_wr_rq_o) |-> $past(mem_ack_i))
    else report_mismatch("request dropped before the memory ack");

  a_wr_landed: assert property (@(posedge clk) disable iff (cpu_reset)
    $rose(cpu_ready_o) && cpu_wr_i && exp_mem |->
      (last_wr_addr == exp_addr && last_wr_data == cpu_data_i))
    else report_mismatch("memory did not receive the CPU write");

  // Expected word addresses per region
  function automatic logic [22:0] direct_addr(input logic [15:0] a);
    return 23'(a[15:1]);                           // Byte address to word address
  endfunction

  function automatic logic [22:0] exp_map_addr(input logic [7:0] page, input logic [15:0] a);
    return ti_map_pkg::SAMS_BASE + 23'(page) * 23'd2048 + 23'(a[11:1]);
  endfunction

  function automatic logic [22:0] cart_addr(input logic [7:0] page, input logic [15:0] a);
    return ti_map_pkg::CART_BASE + 23'(page) * 23'd4096 + 23'(a[12:1]);
  endfunction

  function automatic logic [22:0] window_addr(input logic [15:0] w, input logic [6:0] k);
    return 23'(w) * 23'd128 + 23'(k);
  endfunction

  task automatic finish_run();
    $display("Run complete: %0d error(s)", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  endtask

  // One CPU cycle held until ready
  task automatic cpu_access(input logic [15:0] addr, input logic [15:0] data, input bit wr,
                            input bit to_mem, input logic [22:0] xaddr,
                            input logic [15:0] rdata);
    int unsigned waited;
    @(posedge clk);
    cpu_addr_i  <= addr;
    cpu_data_i  <= data;
    cpu_rd_i    <= !wr;
    cpu_wr_i    <= wr;
    seen_strobe <= 1'b1;
    exp_mem     <= to_mem;
    exp_addr    <= xaddr;
    exp_rdata   <= to_mem ? (xaddr[15:0] ^ 16'h5A5A) : rdata;
    waited = 0;
    do begin
      @(negedge clk);                              // Sample away from the edge
      waited++;
    end while (!cpu_ready_o && waited < READY_TIMEOUT);
    if (!cpu_ready_o) begin
      errors++;
      $display("Timeout: no ready from the DUT for the access at %h", addr);
    end
    @(posedge clk);
    cpu_rd_i <= 1'b0;                              // End the cycle
    cpu_wr_i <= 1'b0;
  endtask

  // Serial bit write with one cru_clk pulse
  task automatic cru_write(input logic [15:0] addr, input logic val);
    @(posedge clk);
    cpu_addr_i <= addr;
    cru_bit_i  <= val;
    @(posedge clk);
    cru_clk_i  <= 1'b1;
    @(posedge clk);
    cru_clk_i  <= 1'b0;
  endtask

  //----------------------------------------
  // CPU program
  //----------------------------------------
  initial begin
    logic [15:0] addr;
    logic [15:0] data;
    void'($urandom(77));
    repeat (2) @(posedge clk);
    cpu_reset <= 1'b0;
    repeat (4) @(posedge clk);                     // Quiet bus after reset
    // ROM and scratchpad
    cpu_access(16'h0124, 16'h0000, RD, MEM, direct_addr(16'h0124), 16'h0000);
    cpu_access(16'h1FFE, 16'h0000, RD, MEM, direct_addr(16'h1FFE), 16'h0000);
    cpu_access(16'h8000, 16'h0000, RD, MEM, direct_addr(16'h8000), 16'h0000);
    cpu_access(16'h83FE, 16'h0000, RD, MEM, direct_addr(16'h83FE), 16'h0000);
    cpu_access(16'h0200, 16'h1234, WR, INT, 23'h0, 16'h0000);  // Protected ROM
    cpu_access(16'h8010, 16'hBEEF, WR, MEM, direct_addr(16'h8010), 16'h0000);
    // Cartridge banks
    cpu_access(16'h6046, 16'h0000, WR, INT, 23'h0, 16'h0000);  // Page 23
    cpu_access(16'h7ABC, 16'h0000, RD, MEM, cart_addr(8'h23, 16'h7ABC), 16'h0000);
    cpu_access(16'h6100, 16'hFFFF, WR, INT, 23'h0, 16'h0000);  // Page 80
    cpu_access(16'h6002, 16'h0000, RD, MEM, cart_addr(8'h80, 16'h6002), 16'h0000);
    // Page mapper registers then mapping on
    cru_write(16'h1E00, 1'b1);
    cpu_access(16'h4006, 16'h5C00, WR, INT, 23'h0, 16'h0000);  // Register 3
    cpu_access(16'h4014, 16'hC300, WR, INT, 23'h0, 16'h0000);  // Register A
    cpu_access(16'h4006, 16'h0000, RD, INT, 23'h0, 16'h5C5C);
    cpu_access(16'h4014, 16'h0000, RD, INT, 23'h0, 16'hC3C3);
    cpu_access(16'h3456, 16'h0000, RD, MEM, exp_map_addr(8'h03, 16'h3456), 16'h0000);
    cpu_access(16'hA010, 16'h0000, RD, MEM, exp_map_addr(8'h0A, 16'hA010), 16'h0000);
    cru_write(16'h1E02, 1'b1);
    cpu_access(16'h3456, 16'h0000, RD, MEM, exp_map_addr(8'h5C, 16'h3456), 16'h0000);
    cpu_access(16'hA010, 16'h0000, RD, MEM, exp_map_addr(8'hC3, 16'hA010), 16'h0000);
    cpu_access(16'hA7FE, 16'h4321, WR, MEM, exp_map_addr(8'hC3, 16'hA7FE), 16'h0000);
    cru_write(16'h1E00, 1'b0);                     // Registers hidden again
    cpu_access(16'h4006, 16'h0000, RD, INT, 23'h0, 16'h0000);
    // Window register and window
    cpu_access(16'h8600, 16'h0123, WR, INT, 23'h0, 16'h0000);
    cpu_access(16'h8600, 16'h0000, RD, INT, 23'h0, 16'h0123);
    cpu_access(16'h850A, 16'h0000, RD, MEM, window_addr(16'h0123, 7'd5), 16'h0000);
    cpu_access(16'h85FE, 16'h7777, WR, MEM, window_addr(16'h0123, 7'h7F), 16'h0000);
    cpu_access(16'h9800, 16'h0000, RD, INT, 23'h0, 16'h0000);  // Unmapped
    // Random scratchpad traffic under back-pressure
    for (int i = 0; i < 24; i++) begin
      addr = 16'h8000 | (16'($urandom) & 16'h03FE);
      data = 16'($urandom);
      if ($urandom_range(1, 0) == 1)
        cpu_access(addr, data, WR, MEM, direct_addr(addr), 16'h0000);
      else
        cpu_access(addr, 16'h0000, RD, MEM, direct_addr(addr), 16'h0000);
    end
    repeat (4) @(posedge clk);
    finish_run();
  end

endmodule
`default_nettype wire

//--- ti_mem_map.f
hdl/ti_map_pkg.sv
hdl/bus_decode.sv
hdl/sams_mapper.sv
hdl/addr_translate.sv
hdl/mem_request.sv
hdl/ti_mem_map.sv
dv/tb_ti_mem_map.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory-mapping core and its testbench with Verilator,
# runs the simulation and decides the result from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f ti_mem_map.f --top-module tb_ti_mem_map -o tb_ti_mem_map
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ti_mem_map > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All tests passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
